// ==== logic/matrix_cfg.svh ====
// ==============================
// Matrix core build constants
// Slot count, largest dimension
// and element width
// ==============================
`ifndef MATRIX_CFG_SVH
`define MATRIX_CFG_SVH

// Number of matrix slots in the store
`define MAT_SLOTS 4

// Largest row or column count
`define MAT_MAX_DIM 4

// Element width in bits
`define MAT_ELEM_W 8

`endif

// ==== logic/matrix_pkg.sv ====
// ==============================
// Matrix core shared types
// Element, dim, index, slot and
// address vectors, ALU opcodes,
// agent FSM state encodings
// ==============================
`include "matrix_cfg.svh"

package matrix_pkg;

  // Widths derived from the build constants
  typedef logic [`MAT_ELEM_W-1:0]                   elem_t;
  typedef logic [$clog2(`MAT_MAX_DIM+1)-1:0]        dim_t;
  typedef logic [$clog2(`MAT_MAX_DIM)-1:0]          idx_t;
  typedef logic [$clog2(`MAT_SLOTS)-1:0]            slot_t;
  // Word address is {slot, row, col}
  typedef logic [$bits(slot_t)+2*$bits(idx_t)-1:0]  addr_t;

  typedef enum logic [1:0] {
    op_add,
    op_scale,
    op_transpose
  } alu_op_t;

  // ALU sequencer
  typedef enum logic [2:0] {
    alu_idle,
    alu_probe_a,
    alu_probe_b,
    alu_read_a,
    alu_read_b,
    alu_write
  } alu_state_t;

  // Byte-stream loader
  typedef enum logic [1:0] {
    ld_rows,
    ld_cols,
    ld_elems,
    ld_wait
  } load_state_t;

endpackage

// ==== logic/matrix_store.sv ====
// ==============================
// Matrix store
// Scalar element RAM, dim table
// per slot, slot valid bits and
// round-robin slot allocator
// ==============================
`timescale 1ns/100ps
`include "matrix_cfg.svh"

module matrix_store (
  input  logic               clk,
  input  logic               arst_n,
  // Write port
  input  logic               wr_en,
  input  logic               wr_new,
  input  matrix_pkg::dim_t   wr_rows,
  input  matrix_pkg::dim_t   wr_cols,
  input  matrix_pkg::idx_t   wr_row,
  input  matrix_pkg::idx_t   wr_col,
  input  matrix_pkg::elem_t  wr_data,
  // Read port, registered
  input  logic               rd_en,
  input  matrix_pkg::slot_t  rd_slot,
  input  matrix_pkg::idx_t   rd_row,
  input  matrix_pkg::idx_t   rd_col,
  output matrix_pkg::elem_t  rd_data,
  output matrix_pkg::dim_t   rd_rows,
  output matrix_pkg::dim_t   rd_cols,
  output logic               rd_empty,
  // Slot written by the latest new matrix
  output matrix_pkg::slot_t  last_id
);
  import matrix_pkg::*;

  elem_t                 mem      [0:`MAT_SLOTS*`MAT_MAX_DIM*`MAT_MAX_DIM-1];
  dim_t                  dim_rows [0:`MAT_SLOTS-1];
  dim_t                  dim_cols [0:`MAT_SLOTS-1];
  logic [`MAT_SLOTS-1:0] slot_vld;
  slot_t                 next_slot;
  slot_t                 wr_slot;
  addr_t                 wr_addr;
  addr_t                 rd_addr;

  // New matrix takes the allocator slot, others extend the last one
  assign wr_slot = wr_new ? next_slot : last_id;
  assign wr_addr = {wr_slot, wr_row, wr_col};
  assign rd_addr = {rd_slot, rd_row, rd_col};

  // ==============================
  // Slot allocation
  // ==============================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot_vld  <= '0;
      next_slot <= '0;
      last_id   <= '0;
    end else if (wr_en && wr_new) begin
      slot_vld[next_slot] <= 1'b1;
      last_id             <= next_slot;
      // Oldest slot gets reused after the last one
      if (next_slot == slot_t'(`MAT_SLOTS - 1))
        next_slot <= '0;
      else
        next_slot <= next_slot + 1'b1;
    end
  end

  // ==============================
  // Element RAM and dim table
  // ==============================
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
      if (wr_new) begin
        dim_rows[wr_slot] <= wr_rows;
        dim_cols[wr_slot] <= wr_cols;
      end
    end
  end

  // Read data and dims, one cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
      rd_rows <= dim_rows[rd_slot];
      rd_cols <= dim_cols[rd_slot];
    end
  end

  // Empty flag follows the valid bit of the slot read
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      rd_empty <= 1'b0;
    else if (rd_en)
      rd_empty <= !slot_vld[rd_slot];
  end

endmodule

// ==== logic/store_arbiter.sv ====
// ==============================
// Store arbiter
// Fixed-priority write select,
// loader over ALU; read select,
// ALU over dump, rd_valid steering
// ==============================
`timescale 1ns/100ps
`include "matrix_cfg.svh"

module store_arbiter (
  input  logic               clk,
  input  logic               arst_n,
  // Loader writer
  input  logic               ld_wr_req,
  input  logic               ld_wr_new,
  input  matrix_pkg::dim_t   ld_wr_rows,
  input  matrix_pkg::dim_t   ld_wr_cols,
  input  matrix_pkg::idx_t   ld_wr_row,
  input  matrix_pkg::idx_t   ld_wr_col,
  input  matrix_pkg::elem_t  ld_wr_data,
  output logic               ld_wr_gnt,
  // ALU writer and reader
  input  logic               alu_wr_req,
  input  logic               alu_wr_new,
  input  matrix_pkg::dim_t   alu_wr_rows,
  input  matrix_pkg::dim_t   alu_wr_cols,
  input  matrix_pkg::idx_t   alu_wr_row,
  input  matrix_pkg::idx_t   alu_wr_col,
  input  matrix_pkg::elem_t  alu_wr_data,
  output logic               alu_wr_gnt,
  input  logic               alu_rd_req,
  input  matrix_pkg::slot_t  alu_rd_slot,
  input  matrix_pkg::idx_t   alu_rd_row,
  input  matrix_pkg::idx_t   alu_rd_col,
  output logic               alu_rd_valid,
  // Dump reader, dump_rd_req is a one-cycle strobe
  input  logic               dump_rd_req,
  input  matrix_pkg::slot_t  dump_slot,
  input  matrix_pkg::idx_t   dump_row,
  input  matrix_pkg::idx_t   dump_col,
  output logic               dump_rd_valid,
  // Store ports
  output logic               wr_en,
  output logic               wr_new,
  output matrix_pkg::dim_t   wr_rows,
  output matrix_pkg::dim_t   wr_cols,
  output matrix_pkg::idx_t   wr_row,
  output matrix_pkg::idx_t   wr_col,
  output matrix_pkg::elem_t  wr_data,
  output logic               rd_en,
  output matrix_pkg::slot_t  rd_slot,
  output matrix_pkg::idx_t   rd_row,
  output matrix_pkg::idx_t   rd_col
);
  import matrix_pkg::*;

  logic  dump_pend;
  logic  dump_gnt;
  slot_t dump_slot_q;
  idx_t  dump_row_q;
  idx_t  dump_col_q;

  // ==============================
  // Write side
  // ==============================
  assign ld_wr_gnt  = ld_wr_req;
  assign alu_wr_gnt = alu_wr_req && !ld_wr_req;
  assign wr_en      = ld_wr_req || alu_wr_req;
  assign wr_new     = ld_wr_req ? ld_wr_new  : alu_wr_new;
  assign wr_rows    = ld_wr_req ? ld_wr_rows : alu_wr_rows;
  assign wr_cols    = ld_wr_req ? ld_wr_cols : alu_wr_cols;
  assign wr_row     = ld_wr_req ? ld_wr_row  : alu_wr_row;
  assign wr_col     = ld_wr_req ? ld_wr_col  : alu_wr_col;
  assign wr_data    = ld_wr_req ? ld_wr_data : alu_wr_data;

  // ==============================
  // Read side
  // ==============================
  // Dump waits in pending while the ALU reads
  assign dump_gnt = dump_pend && !alu_rd_req;
  assign rd_en    = alu_rd_req || dump_pend;
  assign rd_slot  = alu_rd_req ? alu_rd_slot : dump_slot_q;
  assign rd_row   = alu_rd_req ? alu_rd_row  : dump_row_q;
  assign rd_col   = alu_rd_req ? alu_rd_col  : dump_col_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dump_pend     <= 1'b0;
      alu_rd_valid  <= 1'b0;
      dump_rd_valid <= 1'b0;
    end else begin
      // Data returns one cycle after the grant
      alu_rd_valid  <= alu_rd_req;
      dump_rd_valid <= dump_gnt;
      if (dump_rd_req)
        dump_pend <= 1'b1;
      else if (dump_gnt)
        dump_pend <= 1'b0;
    end
  end

  // Dump address held while pending
  always_ff @(posedge clk) begin
    if (dump_rd_req) begin
      dump_slot_q <= dump_slot;
      dump_row_q  <= dump_row;
      dump_col_q  <= dump_col;
    end
  end

endmodule

// ==== logic/matrix_loader.sv ====
// ==============================
// Matrix loader
// Byte-strobe parser: rows, cols,
// then elements in row-major order
// ==============================
`timescale 1ns/100ps
`include "matrix_cfg.svh"

module matrix_loader (
  input  logic               clk,
  input  logic               arst_n,
  input  matrix_pkg::elem_t  rx_byte,
  input  logic               rx_valid,
  input  logic               wr_gnt,
  output logic               wr_req,
  output logic               wr_new,
  output matrix_pkg::dim_t   wr_rows,
  output matrix_pkg::dim_t   wr_cols,
  output matrix_pkg::idx_t   wr_row,
  output matrix_pkg::idx_t   wr_col,
  output matrix_pkg::elem_t  wr_data,
  output logic               load_done,
  output logic               load_err
);
  import matrix_pkg::*;

  load_state_t state;
  logic        last_elem;

  // Dimension byte must lie in 1 to MAT_MAX_DIM
  function automatic logic dim_ok(input elem_t b);
    return (b != '0) && (b <= elem_t'(`MAT_MAX_DIM));
  endfunction

  assign last_elem = (wr_row == idx_t'(wr_rows - 1'b1)) &&
                     (wr_col == idx_t'(wr_cols - 1'b1));

  // ==============================
  // Control FSM
  // ==============================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= ld_rows;
      wr_req    <= 1'b0;
      wr_new    <= 1'b0;
      wr_row    <= '0;
      wr_col    <= '0;
      load_done <= 1'b0;
      load_err  <= 1'b0;
    end else begin
      load_done <= 1'b0;
      load_err  <= 1'b0;
      case (state)
        ld_rows: if (rx_valid) begin
          if (dim_ok(rx_byte))
            state <= ld_cols;
          else
            load_err <= 1'b1;
        end
        ld_cols: if (rx_valid) begin
          if (dim_ok(rx_byte)) begin
            wr_row <= '0;
            wr_col <= '0;
            // First element allocates the slot
            wr_new <= 1'b1;
            state  <= ld_elems;
          end else begin
            load_err <= 1'b1;
            state    <= ld_rows;
          end
        end
        ld_elems: if (rx_valid) begin
          wr_req <= 1'b1;
          state  <= ld_wait;
        end
        ld_wait: if (wr_gnt) begin
          wr_req <= 1'b0;
          wr_new <= 1'b0;
          if (last_elem) begin
            load_done <= 1'b1;
            state     <= ld_rows;
          end else begin
            // Row-major step
            if (wr_col == idx_t'(wr_cols - 1'b1)) begin
              wr_col <= '0;
              wr_row <= wr_row + 1'b1;
            end else begin
              wr_col <= wr_col + 1'b1;
            end
            state <= ld_elems;
          end
        end
        default: state <= ld_rows;
      endcase
    end
  end

  // Dims and element byte captured from the stream
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      case (state)
        ld_rows:  wr_rows <= dim_t'(rx_byte);
        ld_cols:  wr_cols <= dim_t'(rx_byte);
        ld_elems: wr_data <= rx_byte;
        default: ;
      endcase
    end
  end

endmodule

// ==== logic/matrix_alu.sv ====
// ==============================
// Matrix ALU
// Sequential add, scalar multiply
// and transpose over the store,
// with operand checks
// ==============================
`timescale 1ns/100ps
`include "matrix_cfg.svh"

module matrix_alu (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start,
  input  matrix_pkg::alu_op_t  op,
  input  matrix_pkg::slot_t    id_a,
  input  matrix_pkg::slot_t    id_b,
  input  matrix_pkg::elem_t    scalar,
  // Read return
  input  matrix_pkg::elem_t    rd_data,
  input  matrix_pkg::dim_t     rd_rows,
  input  matrix_pkg::dim_t     rd_cols,
  input  logic                 rd_empty,
  input  logic                 rd_valid,
  input  logic                 wr_gnt,
  // Read request, granted in its own cycle
  output logic                 rd_req,
  output matrix_pkg::slot_t    rd_slot,
  output matrix_pkg::idx_t     rd_row,
  output matrix_pkg::idx_t     rd_col,
  // Result write
  output logic                 wr_req,
  output logic                 wr_new,
  output matrix_pkg::dim_t     wr_rows,
  output matrix_pkg::dim_t     wr_cols,
  output matrix_pkg::idx_t     wr_row,
  output matrix_pkg::idx_t     wr_col,
  output matrix_pkg::elem_t    wr_data,
  output logic                 busy,
  output logic                 done,
  output logic                 err
);
  import matrix_pkg::*;

  alu_state_t state;
  alu_op_t    op_q;
  slot_t      id_a_q;
  slot_t      id_b_q;
  elem_t      scalar_q;
  elem_t      a_val;
  idx_t       row_q;
  idx_t       col_q;
  logic       last_elem;

  // B is read only in its own states; transpose reads A at (col, row)
  assign rd_slot = (state == alu_probe_b || state == alu_read_b) ? id_b_q : id_a_q;
  assign rd_row  = (op_q == op_transpose) ? col_q : row_q;
  assign rd_col  = (op_q == op_transpose) ? row_q : col_q;
  assign wr_row  = row_q;
  assign wr_col  = col_q;

  // Result dims sit in wr_rows and wr_cols
  assign last_elem = (row_q == idx_t'(wr_rows - 1'b1)) &&
                     (col_q == idx_t'(wr_cols - 1'b1));

  // ==============================
  // Sequencer
  // ==============================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= alu_idle;
      rd_req <= 1'b0;
      wr_req <= 1'b0;
      wr_new <= 1'b0;
      row_q  <= '0;
      col_q  <= '0;
      busy   <= 1'b0;
      done   <= 1'b0;
      err    <= 1'b0;
    end else begin
      rd_req <= 1'b0;
      done   <= 1'b0;
      err    <= 1'b0;
      case (state)
        alu_idle: if (start) begin
          busy   <= 1'b1;
          row_q  <= '0;
          col_q  <= '0;
          wr_new <= 1'b1;
          rd_req <= 1'b1;
          state  <= alu_probe_a;
        end
        // Probe of A at (0,0) returns its dims
        alu_probe_a: if (rd_valid) begin
          if (rd_empty) begin
            busy  <= 1'b0;
            done  <= 1'b1;
            err   <= 1'b1;
            state <= alu_idle;
          end else begin
            rd_req <= 1'b1;
            state  <= (op_q == op_add) ? alu_probe_b : alu_read_a;
          end
        end
        // Add needs B filled and with the dims of A
        alu_probe_b: if (rd_valid) begin
          if (rd_empty || rd_rows != wr_rows || rd_cols != wr_cols) begin
            busy  <= 1'b0;
            done  <= 1'b1;
            err   <= 1'b1;
            state <= alu_idle;
          end else begin
            rd_req <= 1'b1;
            state  <= alu_read_a;
          end
        end
        alu_read_a: if (rd_valid) begin
          if (op_q == op_add) begin
            rd_req <= 1'b1;
            state  <= alu_read_b;
          end else begin
            wr_req <= 1'b1;
            state  <= alu_write;
          end
        end
        alu_read_b: if (rd_valid) begin
          wr_req <= 1'b1;
          state  <= alu_write;
        end
        alu_write: if (wr_gnt) begin
          wr_req <= 1'b0;
          wr_new <= 1'b0;
          if (last_elem) begin
            busy  <= 1'b0;
            done  <= 1'b1;
            state <= alu_idle;
          end else begin
            if (col_q == idx_t'(wr_cols - 1'b1)) begin
              col_q <= '0;
              row_q <= row_q + 1'b1;
            end else begin
              col_q <= col_q + 1'b1;
            end
            rd_req <= 1'b1;
            state  <= alu_read_a;
          end
        end
        default: state <= alu_idle;
      endcase
    end
  end

  // ==============================
  // Operands and datapath
  // ==============================
  always_ff @(posedge clk) begin
    if (state == alu_idle && start) begin
      op_q     <= op;
      id_a_q   <= id_a;
      id_b_q   <= id_b;
      scalar_q <= scalar;
    end
    if (rd_valid) begin
      case (state)
        // Transpose swaps the result dims
        alu_probe_a: begin
          wr_rows <= (op_q == op_transpose) ? rd_cols : rd_rows;
          wr_cols <= (op_q == op_transpose) ? rd_rows : rd_cols;
        end
        alu_read_a: begin
          a_val   <= rd_data;
          // Low 8 bits of the product
          wr_data <= (op_q == op_scale) ? elem_t'(rd_data * scalar_q) : rd_data;
        end
        // Sum wraps modulo 256
        alu_read_b: wr_data <= a_val + rd_data;
        default: ;
      endcase
    end
  end

endmodule

// ==== logic/matrix_calc_core.sv ====
// ==============================
// Matrix calculator core top
// Loader, ALU, store arbiter and
// matrix store wired together
// ==============================
`timescale 1ns/100ps
`include "matrix_cfg.svh"

module matrix_calc_core (
  input  logic                 clk,
  input  logic                 arst_n,
  // Byte stream into the loader
  input  matrix_pkg::elem_t    rx_byte,
  input  logic                 rx_valid,
  // ALU command
  input  logic                 alu_start,
  input  matrix_pkg::alu_op_t  alu_op,
  input  matrix_pkg::slot_t    id_a,
  input  matrix_pkg::slot_t    id_b,
  input  matrix_pkg::elem_t    scalar,
  // Dump port, dump_req is a one-cycle strobe
  input  logic                 dump_req,
  input  matrix_pkg::slot_t    dump_slot,
  input  matrix_pkg::idx_t     dump_row,
  input  matrix_pkg::idx_t     dump_col,
  output logic                 load_done,
  output logic                 load_err,
  output logic                 alu_busy,
  output logic                 alu_done,
  output logic                 alu_err,
  output matrix_pkg::slot_t    last_id,
  output logic                 dump_valid,
  output matrix_pkg::elem_t    dump_data,
  output matrix_pkg::dim_t     dump_rows,
  output matrix_pkg::dim_t     dump_cols
);

  // Loader write request
  logic                ld_wr_req, ld_wr_new, ld_wr_gnt;
  matrix_pkg::dim_t    ld_wr_rows, ld_wr_cols;
  matrix_pkg::idx_t    ld_wr_row, ld_wr_col;
  matrix_pkg::elem_t   ld_wr_data;

  // ALU write and read requests
  logic                alu_wr_req, alu_wr_new, alu_wr_gnt;
  matrix_pkg::dim_t    alu_wr_rows, alu_wr_cols;
  matrix_pkg::idx_t    alu_wr_row, alu_wr_col;
  matrix_pkg::elem_t   alu_wr_data;
  logic                alu_rd_req, alu_rd_valid;
  matrix_pkg::slot_t   alu_rd_slot;
  matrix_pkg::idx_t    alu_rd_row, alu_rd_col;

  // Granted store ports
  logic                st_wr_en, st_wr_new, st_rd_en, st_rd_empty;
  matrix_pkg::dim_t    st_wr_rows, st_wr_cols, st_rd_rows, st_rd_cols;
  matrix_pkg::idx_t    st_wr_row, st_wr_col, st_rd_row, st_rd_col;
  matrix_pkg::elem_t   st_wr_data, st_rd_data;
  matrix_pkg::slot_t   st_rd_slot;

  // Read return is shared by the ALU and the dump port
  assign dump_data = st_rd_data;
  assign dump_rows = st_rd_rows;
  assign dump_cols = st_rd_cols;

  matrix_loader u_loader (
    .clk(clk), .arst_n(arst_n),
    .rx_byte(rx_byte), .rx_valid(rx_valid), .wr_gnt(ld_wr_gnt),
    .wr_req(ld_wr_req), .wr_new(ld_wr_new),
    .wr_rows(ld_wr_rows), .wr_cols(ld_wr_cols),
    .wr_row(ld_wr_row), .wr_col(ld_wr_col), .wr_data(ld_wr_data),
    .load_done(load_done), .load_err(load_err)
  );

  matrix_alu u_alu (
    .clk(clk), .arst_n(arst_n),
    .start(alu_start), .op(alu_op), .id_a(id_a), .id_b(id_b), .scalar(scalar),
    .rd_data(st_rd_data), .rd_rows(st_rd_rows), .rd_cols(st_rd_cols),
    .rd_empty(st_rd_empty), .rd_valid(alu_rd_valid), .wr_gnt(alu_wr_gnt),
    .rd_req(alu_rd_req), .rd_slot(alu_rd_slot),
    .rd_row(alu_rd_row), .rd_col(alu_rd_col),
    .wr_req(alu_wr_req), .wr_new(alu_wr_new),
    .wr_rows(alu_wr_rows), .wr_cols(alu_wr_cols),
    .wr_row(alu_wr_row), .wr_col(alu_wr_col), .wr_data(alu_wr_data),
    .busy(alu_busy), .done(alu_done), .err(alu_err)
  );

  store_arbiter u_arbiter (
    .clk(clk), .arst_n(arst_n),
    .ld_wr_req(ld_wr_req), .ld_wr_new(ld_wr_new),
    .ld_wr_rows(ld_wr_rows), .ld_wr_cols(ld_wr_cols),
    .ld_wr_row(ld_wr_row), .ld_wr_col(ld_wr_col),
    .ld_wr_data(ld_wr_data), .ld_wr_gnt(ld_wr_gnt),
    .alu_wr_req(alu_wr_req), .alu_wr_new(alu_wr_new),
    .alu_wr_rows(alu_wr_rows), .alu_wr_cols(alu_wr_cols),
    .alu_wr_row(alu_wr_row), .alu_wr_col(alu_wr_col),
    .alu_wr_data(alu_wr_data), .alu_wr_gnt(alu_wr_gnt),
    .alu_rd_req(alu_rd_req), .alu_rd_slot(alu_rd_slot),
    .alu_rd_row(alu_rd_row), .alu_rd_col(alu_rd_col), .alu_rd_valid(alu_rd_valid),
    .dump_rd_req(dump_req), .dump_slot(dump_slot),
    .dump_row(dump_row), .dump_col(dump_col), .dump_rd_valid(dump_valid),
    .wr_en(st_wr_en), .wr_new(st_wr_new),
    .wr_rows(st_wr_rows), .wr_cols(st_wr_cols),
    .wr_row(st_wr_row), .wr_col(st_wr_col), .wr_data(st_wr_data),
    .rd_en(st_rd_en), .rd_slot(st_rd_slot),
    .rd_row(st_rd_row), .rd_col(st_rd_col)
  );

  matrix_store u_store (
    .clk(clk), .arst_n(arst_n),
    .wr_en(st_wr_en), .wr_new(st_wr_new),
    .wr_rows(st_wr_rows), .wr_cols(st_wr_cols),
    .wr_row(st_wr_row), .wr_col(st_wr_col), .wr_data(st_wr_data),
    .rd_en(st_rd_en), .rd_slot(st_rd_slot),
    .rd_row(st_rd_row), .rd_col(st_rd_col),
    .rd_data(st_rd_data), .rd_rows(st_rd_rows), .rd_cols(st_rd_cols),
    .rd_empty(st_rd_empty), .last_id(last_id)
  );

endmodule

// ==== tests/tb_matrix_calc_core.sv ====
// ==============================
// Matrix calculator core testbench
// Clock, reset, byte-stream and
// ALU stimulus, slot model with
// reference function, dump checker
// ==============================
`timescale 1ns/100ps
`include "matrix_cfg.svh"

module tb_matrix_calc_core;
  import matrix_pkg::*;

  localparam int timeout_cycles = 300;
  localparam int sel_load_done  = 0;
  localparam int sel_load_err   = 1;
  localparam int sel_alu_done   = 2;

  logic    clk = 1'b0;
  logic    arst_n;
  elem_t   rx_byte;
  logic    rx_valid;
  logic    alu_start;
  alu_op_t alu_op;
  slot_t   id_a;
  slot_t   id_b;
  elem_t   scalar;
  logic    dump_req;
  slot_t   dump_slot;
  idx_t    dump_row;
  idx_t    dump_col;
  logic    load_done;
  logic    load_err;
  logic    alu_busy;
  logic    alu_done;
  logic    alu_err;
  slot_t   last_id;
  logic    dump_valid;
  elem_t   dump_data;
  dim_t    dump_rows;
  dim_t    dump_cols;

  // ==============================
  // Slot model
  // ==============================
  elem_t       model_mem  [0:`MAT_SLOTS-1][0:`MAT_MAX_DIM-1][0:`MAT_MAX_DIM-1];
  dim_t        model_rows [0:`MAT_SLOTS-1];
  dim_t        model_cols [0:`MAT_SLOTS-1];
  logic        model_vld  [0:`MAT_SLOTS-1];
  slot_t       model_next;
  slot_t       model_last;
  logic [31:0] rng;
  int          errors;
  int          checks;
  int          test_base;
  slot_t       s_a;
  slot_t       s_b;
  elem_t       k;
  // Expected dump results with the oldest first
  elem_t       exp_data [$];
  dim_t        exp_rows [$];
  dim_t        exp_cols [$];
  string       exp_tag  [$];
  string       dump_tag;

  matrix_calc_core u_dut (
    .clk(clk), .arst_n(arst_n),
    .rx_byte(rx_byte), .rx_valid(rx_valid),
    .alu_start(alu_start), .alu_op(alu_op), .id_a(id_a), .id_b(id_b), .scalar(scalar),
    .dump_req(dump_req), .dump_slot(dump_slot), .dump_row(dump_row), .dump_col(dump_col),
    .load_done(load_done), .load_err(load_err),
    .alu_busy(alu_busy), .alu_done(alu_done), .alu_err(alu_err),
    .last_id(last_id),
    .dump_valid(dump_valid), .dump_data(dump_data),
    .dump_rows(dump_rows), .dump_cols(dump_cols)
  );

  // 20 ns clock
  initial begin
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output elem_t v);
    rng = xorshift32(rng);
    v   = rng[7:0];
  endtask

  // Expected result element at (r, c) from the slot model
  function automatic elem_t ref_elem(input alu_op_t op, input slot_t a, input slot_t b,
                                     input elem_t kk, input idx_t r, input idx_t c);
    logic [15:0] prod;
    case (op)
      op_add:   return model_mem[a][r][c] + model_mem[b][r][c];
      op_scale: begin
        prod = 16'(model_mem[a][r][c]) * 16'(kk);
        return prod[7:0];
      end
      default:  return model_mem[a][c][r];
    endcase
  endfunction

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_elem(input string name, input elem_t got, input elem_t exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_dim(input string name, input dim_t got, input dim_t exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_slot(input string name, input slot_t got, input slot_t exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // Dump results checked as they arrive
  always @(negedge clk) begin
    if (dump_valid) begin
      if (exp_data.size() == 0) begin
        $display("dump_valid went high with no dump request pending");
        errors++;
      end else begin
        dump_tag = exp_tag.pop_front();
        check_elem({"dump_data ", dump_tag}, dump_data, exp_data.pop_front());
        check_dim({"dump_rows ", dump_tag}, dump_rows, exp_rows.pop_front());
        check_dim({"dump_cols ", dump_tag}, dump_cols, exp_cols.pop_front());
      end
    end
  end

  // ==============================
  // Stimulus tasks
  // ==============================
  function automatic logic watched(input int sel);
    case (sel)
      sel_load_done: return load_done;
      sel_load_err:  return load_err;
      default:       return alu_done;
    endcase
  endfunction

  // Polls on falling edges starting with the current one
  task automatic wait_for(input int sel, input string what);
    int n;
    n = 0;
    while (!watched(sel) && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!watched(sel)) begin
      $display("timeout: %s never went high", what);
      errors++;
    end
  endtask

  // Rising edges, so the checker has run on the falling edge before
  task automatic wait_dump_results();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (exp_data.size() != 0 && n < timeout_cycles);
    if (exp_data.size() != 0) begin
      $display("timeout: dump_valid never went high for %0d requests", exp_data.size());
      errors++;
      exp_data.delete();
      exp_rows.delete();
      exp_cols.delete();
      exp_tag.delete();
    end
  endtask

  task automatic apply_reset();
    arst_n    = 1'b0;
    rx_byte   = '0;
    rx_valid  = 1'b0;
    alu_start = 1'b0;
    alu_op    = op_add;
    id_a      = '0;
    id_b      = '0;
    scalar    = '0;
    dump_req  = 1'b0;
    dump_slot = '0;
    dump_row  = '0;
    dump_col  = '0;
    for (int s = 0; s < `MAT_SLOTS; s++)
      model_vld[s] = 1'b0;
    model_next = '0;
    model_last = '0;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
  endtask

  // Strobes 6 cycles apart
  task automatic send_byte(input elem_t b);
    repeat (5) @(negedge clk);
    rx_byte  = b;
    rx_valid = 1'b1;
    @(negedge clk);
    rx_valid = 1'b0;
  endtask

  task automatic load_matrix(input dim_t rows, input dim_t cols);
    elem_t v;
    send_byte(elem_t'(rows));
    send_byte(elem_t'(cols));
    for (int r = 0; r < int'(rows); r++) begin
      for (int c = 0; c < int'(cols); c++) begin
        next_rand(v);
        model_mem[model_next][idx_t'(r)][idx_t'(c)] = v;
        send_byte(v);
      end
    end
    wait_for(sel_load_done, "load_done");
    // New matrix takes the next slot in round robin
    model_rows[model_next] = rows;
    model_cols[model_next] = cols;
    model_vld[model_next]  = 1'b1;
    model_last             = model_next;
    model_next             = model_next + 1'b1;
    check_slot("last_id", last_id, model_last);
  endtask

  task automatic run_alu(input alu_op_t op, input slot_t a, input slot_t b, input elem_t kk);
    logic  exp_err;
    dim_t  rr;
    dim_t  rc;
    elem_t res [0:`MAT_MAX_DIM-1][0:`MAT_MAX_DIM-1];
    // Empty operand, or add with mismatched dims
    exp_err = !model_vld[a] ||
              (op == op_add && (!model_vld[b] || model_rows[a] != model_rows[b] ||
                                model_cols[a] != model_cols[b]));
    @(negedge clk);
    alu_op    = op;
    id_a      = a;
    id_b      = b;
    scalar    = kk;
    alu_start = 1'b1;
    @(negedge clk);
    alu_start = 1'b0;
    check_flag("alu_busy", alu_busy, 1'b1);
    wait_for(sel_alu_done, "alu_done");
    check_flag("alu_err", alu_err, exp_err);
    check_flag("alu_busy", alu_busy, 1'b0);
    if (!exp_err) begin
      rr = (op == op_transpose) ? model_cols[a] : model_rows[a];
      rc = (op == op_transpose) ? model_rows[a] : model_cols[a];
      // Result built apart so a source slot is read before it is reused
      for (int r = 0; r < int'(rr); r++)
        for (int c = 0; c < int'(rc); c++)
          res[r][c] = ref_elem(op, a, b, kk, idx_t'(r), idx_t'(c));
      for (int r = 0; r < int'(rr); r++)
        for (int c = 0; c < int'(rc); c++)
          model_mem[model_next][idx_t'(r)][idx_t'(c)] = res[r][c];
      model_rows[model_next] = rr;
      model_cols[model_next] = rc;
      model_vld[model_next]  = 1'b1;
      model_last             = model_next;
      model_next             = model_next + 1'b1;
    end
    check_slot("last_id", last_id, model_last);
  endtask

  // Reads back a whole slot through the dump port
  task automatic dump_check(input slot_t s);
    for (int r = 0; r < int'(model_rows[s]); r++) begin
      for (int c = 0; c < int'(model_cols[s]); c++) begin
        exp_data.push_back(model_mem[s][idx_t'(r)][idx_t'(c)]);
        exp_rows.push_back(model_rows[s]);
        exp_cols.push_back(model_cols[s]);
        exp_tag.push_back($sformatf("slot %0d (%0d,%0d)", s, r, c));
        @(negedge clk);
        dump_slot = s;
        dump_row  = idx_t'(r);
        dump_col  = idx_t'(c);
        dump_req  = 1'b1;
        @(negedge clk);
        dump_req = 1'b0;
        wait_dump_results();
      end
    end
  endtask

  task automatic end_test(input int num, input string name);
    if (errors == test_base)
      $display("test %0d %s: ok", num, name);
    else
      $display("test %0d %s: %0d errors", num, name, errors - test_base);
    test_base = errors;
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    rng       = 32'd65411;
    errors    = 0;
    checks    = 0;
    test_base = 0;
    apply_reset();

    load_matrix(3'd3, 3'd2);
    dump_check(model_last);
    end_test(1, "load 3x2 and dump");

    load_matrix(3'd2, 3'd3);
    s_a = model_last;
    load_matrix(3'd2, 3'd3);
    s_b = model_last;
    run_alu(op_add, s_a, s_b, 8'd0);
    dump_check(model_last);
    end_test(2, "add 2x3");

    next_rand(k);
    run_alu(op_scale, s_a, s_a, k);
    dump_check(model_last);
    end_test(3, "scale by random scalar");

    load_matrix(3'd2, 3'd4);
    s_a = model_last;
    run_alu(op_transpose, s_a, s_a, 8'd0);
    dump_check(model_last);
    end_test(4, "transpose 2x4");

    // Mismatched add, then a row count out of range
    load_matrix(3'd2, 3'd2);
    s_a = model_last;
    load_matrix(3'd3, 3'd3);
    s_b = model_last;
    run_alu(op_add, s_a, s_b, 8'd0);
    send_byte(8'd5);
    wait_for(sel_load_err, "load_err");
    check_slot("last_id", last_id, model_last);
    end_test(5, "operand and dimension errors");

    // Allocation restarts at slot 0 and wraps
    apply_reset();
    load_matrix(3'd1, 3'd1);
    load_matrix(3'd2, 3'd3);
    load_matrix(3'd4, 3'd4);
    load_matrix(3'd3, 3'd1);
    load_matrix(3'd2, 3'd2);
    load_matrix(3'd4, 3'd1);
    for (int s = 0; s < `MAT_SLOTS; s++)
      dump_check(slot_t'(s));
    end_test(6, "slot wrap and overwrite");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/matrix_pkg.sv
logic/matrix_store.sv
logic/store_arbiter.sv
logic/matrix_loader.sv
logic/matrix_alu.sv
logic/matrix_calc_core.sv
tests/tb_matrix_calc_core.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_matrix_calc_core

.PHONY: run clean

run: $(SIM)
	$(SIM) | tee sim.log
	! grep -q "Some tests failed" sim.log
	grep -q "All tests passed" sim.log

$(SIM): verilog.f $(wildcard logic/*.sv logic/*.svh tests/*.sv)
	verilator --binary --timing --timescale 1ns/100ps -f verilog.f \
		--top-module tb_matrix_calc_core

clean:
	rm -rf obj_dir sim.log
